//--- design/vertex_pkg.sv
package vertex_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int addr_bits     = 64;
	localparam int vertex_bits   = 32;
	localparam int line_vertices = 32;
	localparam int count_bits    = 32;
	localparam int vertex_bytes  = vertex_bits / 8;
	// one cache line of array elements
	localparam int line_bytes    = line_vertices * vertex_bytes;
	// element count runs 1 to line_vertices
	localparam int elem_bits     = $clog2(line_vertices + 1);
	localparam int size_bits     = $clog2(line_bytes + 1);

	////////////////////////////////////////////////////////////////////////////
	// array tags and transfer records
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic {
		tag_out_degree = 1'b0,
		tag_edges_idx  = 1'b1
	} array_tag_t;

	typedef struct packed {
		logic [count_bits-1:0] vertex_count;
		logic [addr_bits-1:0]  out_degree_base;
		logic [addr_bits-1:0]  edges_idx_base;
	} job_desc_t;

	typedef struct packed {
		logic [addr_bits-1:0] address;
		array_tag_t           tag;
		logic [elem_bits-1:0] elem_count;
		logic [size_bits-1:0] byte_size;
	} read_cmd_t;

	// element j of the line sits at data[j]
	typedef struct packed {
		array_tag_t                                tag;
		logic [elem_bits-1:0]                      elem_count;
		logic [line_vertices-1:0][vertex_bits-1:0] data;
	} read_line_t;

	typedef struct packed {
		logic [count_bits-1:0]  id;
		logic [vertex_bits-1:0] inv_out_degree;
		logic [vertex_bits-1:0] inv_edges_idx;
	} vertex_job_t;

endpackage

//--- design/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  depth     = 4
) (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       push,
	input  payload_t                   push_data,
	input  logic                       pop,
	output logic                       pop_valid,
	output payload_t                   pop_data,
	output logic                       empty,
	output logic [$clog2(depth+1)-1:0] free_count
);

	localparam int count_w = $clog2(depth + 1);
	localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;

	payload_t           mem [depth];
	logic [ptr_w-1:0]   wr_ptr;
	logic [ptr_w-1:0]   rd_ptr;
	logic [count_w-1:0] count;
	logic               full;
	logic               do_pop;

	// wrap at depth so any depth works
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign empty      = (count == '0);
	assign full       = (count == count_w'(depth));
	assign free_count = count_w'(depth) - count;
	// pop on an empty queue is dropped
	assign do_pop     = pop && !empty;

	////////////////////////////////////////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			pop_valid <= 1'b0;
		end else begin
			pop_valid <= do_pop;
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// storage and registered read port
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= push_data;
		if (do_pop)
			pop_data <= mem[rd_ptr];
	end

	// producer must hold off when no room is left
	assert property (@(posedge clock) disable iff (!rstn) push |-> !full)
		else $error("sync_fifo push while full");

	// an empty queue has both pointers on the same slot
	assert property (@(posedge clock) disable iff (!rstn) empty |-> (wr_ptr == rd_ptr))
		else $error("sync_fifo empty count with pointers apart");

endmodule

//--- design/vertex_read_sequencer.sv
`timescale 1ns/100ps

module vertex_read_sequencer #(
	parameter int line_vertices_free = vertex_pkg::line_vertices,
	parameter int free_bits          = $clog2(2 * vertex_pkg::line_vertices + 1)
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  start,
	input  vertex_pkg::job_desc_t job_desc,
	input  logic                  cmd_queue_empty,
	input  logic [free_bits-1:0]  job_free_count,
	input  logic                  line_done,
	output logic                  cmd_push,
	output vertex_pkg::read_cmd_t cmd,
	output logic                  busy
);

	import vertex_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_wait_room,
		st_issue_out,
		st_issue_edges,
		st_wait_unpack
	} seq_state_t;

	seq_state_t            state;
	seq_state_t            next_state;
	job_desc_t             desc_q;
	logic [count_bits-1:0] remaining;
	logic [addr_bits-1:0]  offset;
	logic [elem_bits-1:0]  chunk_elems;
	logic                  room_ok;

	// last chunk may be short
	assign chunk_elems = (remaining > count_bits'(line_vertices)) ?
		elem_bits'(line_vertices) : remaining[elem_bits-1:0];

	// unpacker is idle by construction once line_done was seen
	assign room_ok = cmd_queue_empty &&
		(job_free_count >= free_bits'(line_vertices_free));

	////////////////////////////////////////////////////////////////////////////
	// job FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			state <= st_idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			st_idle: begin
				if (start)
					next_state = st_wait_room;
			end
			st_wait_room: begin
				// zero vertex job ends here
				if (remaining == '0)
					next_state = st_idle;
				else if (room_ok)
					next_state = st_issue_out;
			end
			st_issue_out: begin
				next_state = st_issue_edges;
			end
			st_issue_edges: begin
				next_state = st_wait_unpack;
			end
			st_wait_unpack: begin
				if (line_done)
					next_state = (remaining == '0) ? st_idle : st_wait_room;
			end
			default: begin
				next_state = st_idle;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// vertex countdown and line offset
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining <= '0;
			offset    <= '0;
		end else begin
			if (state == st_idle && start) begin
				remaining <= job_desc.vertex_count;
				offset    <= '0;
			end else if (state == st_issue_edges) begin
				remaining <= remaining - count_bits'(chunk_elems);
				offset    <= offset + addr_bits'(line_bytes);
			end
		end
	end

	// descriptor held for the whole job
	always_ff @(posedge clock) begin
		if (state == st_idle && start)
			desc_q <= job_desc;
	end

	////////////////////////////////////////////////////////////////////////////
	// command build
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		cmd.elem_count = chunk_elems;
		cmd.byte_size  = size_bits'(chunk_elems * vertex_bytes);
		if (state == st_issue_edges) begin
			cmd.address = desc_q.edges_idx_base + offset;
			cmd.tag     = tag_edges_idx;
		end else begin
			cmd.address = desc_q.out_degree_base + offset;
			cmd.tag     = tag_out_degree;
		end
	end

	assign cmd_push = (state == st_issue_out) || (state == st_issue_edges);
	assign busy     = (state != st_idle);

	// chunk size comes from the running countdown
	assert property (@(posedge clock) disable iff (!rstn)
		cmd_push |-> (cmd.elem_count >= 1) && (cmd.elem_count <= line_vertices))
		else $error("read command element count out of range");

endmodule

//--- design/vertex_line_unpacker.sv
`timescale 1ns/100ps

module vertex_line_unpacker (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    start,
	input  logic                    read_data_valid,
	input  vertex_pkg::read_line_t  read_line,
	output logic                    job_push,
	output vertex_pkg::vertex_job_t job,
	output logic                    line_done
);

	import vertex_pkg::*;

	logic [line_vertices-1:0][vertex_bits-1:0] out_line;
	logic [line_vertices-1:0][vertex_bits-1:0] edges_line;
	logic                                      have_out;
	logic                                      have_edges;
	logic [elem_bits-1:0]                      line_count;
	logic [elem_bits-1:0]                      shift_count;
	logic [count_bits-1:0]                     next_id;
	logic                                      shifting;
	logic                                      last_elem;
	logic                                      is_out;

	// both halves of the chunk present
	assign shifting  = have_out && have_edges;
	assign last_elem = (shift_count == line_count - elem_bits'(1));
	assign is_out    = (read_line.tag == tag_out_degree);

	////////////////////////////////////////////////////////////////////////////
	// line capture and shift
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (read_data_valid && is_out)
			out_line <= read_line.data;
		else if (shifting)
			out_line <= out_line >> vertex_bits;

		if (read_data_valid && !is_out)
			edges_line <= read_line.data;
		else if (shifting)
			edges_line <= edges_line >> vertex_bits;

		// element zero is the next vertex
		if (shifting) begin
			job.id             <= next_id;
			job.inv_out_degree <= out_line[0];
			job.inv_edges_idx  <= edges_line[0];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// flags, counters and strobes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			have_out    <= 1'b0;
			have_edges  <= 1'b0;
			line_count  <= '0;
			shift_count <= '0;
			next_id     <= '0;
			job_push    <= 1'b0;
			line_done   <= 1'b0;
		end else begin
			job_push  <= 1'b0;
			line_done <= 1'b0;

			if (read_data_valid) begin
				line_count <= read_line.elem_count;
				if (is_out)
					have_out <= 1'b1;
				else
					have_edges <= 1'b1;
			end

			if (shifting) begin
				job_push <= 1'b1;
				next_id  <= next_id + 1'b1;
				if (last_elem) begin
					// chunk finished so release both lines
					have_out    <= 1'b0;
					have_edges  <= 1'b0;
					shift_count <= '0;
					line_done   <= 1'b1;
				end else begin
					shift_count <= shift_count + 1'b1;
				end
			end

			// new job numbers from zero
			if (start)
				next_id <= '0;
		end
	end

	// second line of a chunk must match the first one
	assert property (@(posedge clock) disable iff (!rstn)
		read_data_valid && (have_out || have_edges) |-> read_line.elem_count == line_count)
		else $error("chunk lines carry different element counts");

	assert property (@(posedge clock) disable iff (!rstn)
		read_data_valid |-> !(is_out ? have_out : have_edges))
		else $error("line arrived for an array already held");

endmodule

//--- design/vertex_job_control.sv
`timescale 1ns/100ps

module vertex_job_control #(
	parameter int job_depth = 2 * vertex_pkg::line_vertices
) (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    start,
	input  vertex_pkg::job_desc_t   job_desc,
	output logic                    read_request,
	input  logic                    read_grant,
	output logic                    read_cmd_valid,
	output vertex_pkg::read_cmd_t   read_cmd,
	input  logic                    read_data_valid,
	input  vertex_pkg::read_line_t  read_line,
	input  logic                    vertex_request,
	output logic                    vertex_valid,
	output vertex_pkg::vertex_job_t vertex,
	output logic                    busy
);

	import vertex_pkg::*;

	localparam int cmd_depth     = 4;
	localparam int job_free_bits = $clog2(job_depth + 1);

	logic                     cmd_push;
	read_cmd_t                cmd;
	logic                     cmd_empty;
	logic                     job_start;
	logic                     job_push;
	vertex_job_t              job;
	logic                     line_done;
	logic [job_free_bits-1:0] job_free_count;

	// start counts only while no job runs
	assign job_start    = start && !busy;
	assign read_request = !cmd_empty;

	vertex_read_sequencer #(
		.line_vertices_free(line_vertices),
		.free_bits         (job_free_bits)
	) u_sequencer (
		.clock          (clock),
		.rstn           (rstn),
		.start          (start),
		.job_desc       (job_desc),
		.cmd_queue_empty(cmd_empty),
		.job_free_count (job_free_count),
		.line_done      (line_done),
		.cmd_push       (cmd_push),
		.cmd            (cmd),
		.busy           (busy)
	);

	sync_fifo #(
		.payload_t(read_cmd_t),
		.depth    (cmd_depth)
	) u_cmd_queue (
		.clock     (clock),
		.rstn      (rstn),
		.push      (cmd_push),
		.push_data (cmd),
		.pop       (read_grant),
		.pop_valid (read_cmd_valid),
		.pop_data  (read_cmd),
		.empty     (cmd_empty),
		.free_count()
	);

	vertex_line_unpacker u_unpacker (
		.clock          (clock),
		.rstn           (rstn),
		.start          (job_start),
		.read_data_valid(read_data_valid),
		.read_line      (read_line),
		.job_push       (job_push),
		.job            (job),
		.line_done      (line_done)
	);

	sync_fifo #(
		.payload_t(vertex_job_t),
		.depth    (job_depth)
	) u_job_queue (
		.clock     (clock),
		.rstn      (rstn),
		.push      (job_push),
		.push_data (job),
		.pop       (vertex_request),
		.pop_valid (vertex_valid),
		.pop_data  (vertex),
		.empty     (),
		.free_count(job_free_count)
	);

	// bus side may only grant a pending request
	assert property (@(posedge clock) disable iff (!rstn) read_grant |-> read_request)
		else $error("read_grant without read_request");

endmodule

//--- sim/tb_vertex_job_control.sv
`timescale 1ns/100ps

module tb_vertex_job_control;

	import vertex_pkg::*;

	localparam int clock_period    = 4;
	// 100, 32, 1, 200, 70 and 45 vertex jobs
	localparam int total_vertices  = 100 + 32 + 1 + 200 + 70 + 45;
	localparam int watchdog_cycles = 200 * total_vertices + 2000;
	// long enough for two chunks to land and shift out
	localparam int hold_window     = 150;

	logic        clock;
	logic        rstn;
	logic        start;
	job_desc_t   job_desc;
	logic        read_request;
	logic        read_grant;
	logic        read_cmd_valid;
	read_cmd_t   read_cmd;
	logic        read_data_valid;
	read_line_t  read_line;
	logic        vertex_request;
	logic        vertex_valid;
	vertex_job_t vertex;
	logic        busy;

	integer      seed = 81048;
	int          cycle = 0;
	job_desc_t   cur_desc;
	int          cmd_index;
	int          vertex_index;
	logic        consume_en = 1'b0;
	logic        grant_prev;
	// granted commands waiting for their data line
	read_cmd_t   pend_cmd [$];
	int          pend_due [$];

	vertex_job_control #(
		.job_depth(2 * line_vertices)
	) DUT (
		.clock          (clock),
		.rstn           (rstn),
		.start          (start),
		.job_desc       (job_desc),
		.read_request   (read_request),
		.read_grant     (read_grant),
		.read_cmd_valid (read_cmd_valid),
		.read_cmd       (read_cmd),
		.read_data_valid(read_data_valid),
		.read_line      (read_line),
		.vertex_request (vertex_request),
		.vertex_valid   (vertex_valid),
		.vertex         (vertex),
		.busy           (busy)
	);

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic int chunk_total(input job_desc_t desc);
		return (int'(desc.vertex_count) + line_vertices - 1) / line_vertices;
	endfunction

	// even n is the out-degree read, odd n the edges-index read
	function automatic read_cmd_t expected_cmd(input job_desc_t desc, input int n);
		read_cmd_t   c;
		int          k;
		int          left;
		logic [63:0] base;
		k    = n / 2;
		left = int'(desc.vertex_count) - k * line_vertices;
		if (left > line_vertices)
			left = line_vertices;
		base         = (n % 2 == 0) ? desc.out_degree_base : desc.edges_idx_base;
		c.tag        = (n % 2 == 0) ? tag_out_degree : tag_edges_idx;
		c.address    = base + 64'(k * line_vertices * 4);
		c.elem_count = elem_bits'(left);
		c.byte_size  = size_bits'(left * 4);
		return c;
	endfunction

	// each element holds its own byte address
	function automatic vertex_job_t expected_vertex(input job_desc_t desc, input int i);
		vertex_job_t v;
		logic [63:0] off;
		off              = 64'(i) * 4;
		v.id             = 32'(i);
		v.inv_out_degree = 32'(desc.out_degree_base + off);
		v.inv_edges_idx  = 32'(desc.edges_idx_base + off);
		return v;
	endfunction

	function automatic read_line_t build_line(input read_cmd_t c);
		read_line_t l;
		int         j;
		l.tag        = c.tag;
		l.elem_count = c.elem_count;
		for (j = 0; j < line_vertices; j++)
			l.data[j] = 32'(c.address + 64'(4 * j));
		return l;
	endfunction

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at first error");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// clock, cycle count, watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clock = 1'b0;
		forever #(clock_period / 2) clock = ~clock;
	end

	always @(posedge clock)
		cycle <= cycle + 1;

	initial begin : watchdog
		repeat (watchdog_cycles) @(posedge clock);
		stop_on_error($sformatf("run timed out after %0d cycles", watchdog_cycles));
	end

	////////////////////////////////////////////////////////////////////////////
	// memory responder and consumer
	////////////////////////////////////////////////////////////////////////////

	initial begin : responder
		int idx;
		int i;
		read_grant      = 1'b0;
		read_data_valid = 1'b0;
		read_line       = '0;
		forever begin
			@(posedge clock);
			#1;
			read_grant      = 1'b0;
			read_data_valid = 1'b0;
			if (rstn && read_request && (($random(seed) & 1) == 1))
				read_grant = 1'b1;
			// oldest due line first, one per cycle
			idx = -1;
			for (i = 0; i < pend_due.size(); i++) begin
				if (idx < 0 && pend_due[i] <= cycle)
					idx = i;
			end
			if (idx >= 0) begin
				read_line       = build_line(pend_cmd[idx]);
				read_data_valid = 1'b1;
				pend_cmd.delete(idx);
				pend_due.delete(idx);
			end
		end
	end

	initial begin : consumer
		vertex_request = 1'b0;
		forever begin
			@(posedge clock);
			#1;
			vertex_request = consume_en && (($random(seed) & 3) != 0);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// compare process
	////////////////////////////////////////////////////////////////////////////

	initial begin : compare
		read_cmd_t   exp_cmd;
		vertex_job_t exp_vertex;
		grant_prev = 1'b0;
		forever begin
			@(negedge clock);
			if (rstn) begin
				// command comes out exactly one cycle after its grant
				assert (read_cmd_valid === grant_prev) else
					stop_on_error($sformatf("ERR read_cmd_valid got %h expected %h",
						read_cmd_valid, grant_prev));
				if (read_cmd_valid) begin
					assert (cmd_index < 2 * chunk_total(cur_desc)) else
						stop_on_error("a read command came after the job had issued all of them");
					exp_cmd = expected_cmd(cur_desc, cmd_index);
					assert (read_cmd === exp_cmd) else
						stop_on_error($sformatf("ERR read_cmd got %h expected %h",
							read_cmd, exp_cmd));
					pend_cmd.push_back(read_cmd);
					pend_due.push_back(cycle + 2 + ($unsigned($random(seed)) % 19));
					cmd_index++;
				end
				if (vertex_valid) begin
					assert (vertex_index < int'(cur_desc.vertex_count)) else
						stop_on_error("a vertex came out when no vertex was expected");
					exp_vertex = expected_vertex(cur_desc, vertex_index);
					assert (vertex === exp_vertex) else
						stop_on_error($sformatf("ERR vertex got %h expected %h",
							vertex, exp_vertex));
					vertex_index++;
				end
			end
			grant_prev = read_grant;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// job tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_idle_outputs;
		assert (read_request === 1'b0) else
			stop_on_error($sformatf("ERR read_request got %h expected 0", read_request));
		assert (read_cmd_valid === 1'b0) else
			stop_on_error($sformatf("ERR read_cmd_valid got %h expected 0", read_cmd_valid));
		assert (vertex_valid === 1'b0) else
			stop_on_error($sformatf("ERR vertex_valid got %h expected 0", vertex_valid));
		assert (busy === 1'b0) else
			stop_on_error($sformatf("ERR busy got %h expected 0", busy));
	endtask

	task automatic start_job(input int count, input logic [63:0] out_base,
		input logic [63:0] edges_base);
		job_desc_t desc;
		desc.vertex_count    = 32'(count);
		desc.out_degree_base = out_base;
		desc.edges_idx_base  = edges_base;
		while (busy)
			@(negedge clock);
		cur_desc     = desc;
		cmd_index    = 0;
		vertex_index = 0;
		@(posedge clock);
		#1;
		start    = 1'b1;
		job_desc = desc;
		@(posedge clock);
		#1;
		start = 1'b0;
		@(negedge clock);
		assert (busy === 1'b1) else
			stop_on_error("busy did not rise after an accepted start");
	endtask

	// second descriptor while busy must leave no trace
	task automatic send_stray_start;
		job_desc_t stray;
		stray.vertex_count    = 32'd5;
		stray.out_degree_base = 64'hffff_0000_0000_0000;
		stray.edges_idx_base  = 64'heeee_0000_0000_0000;
		assert (busy === 1'b1) else
			stop_on_error("job ended before the stray start could be given");
		@(posedge clock);
		#1;
		start    = 1'b1;
		job_desc = stray;
		@(posedge clock);
		#1;
		start    = 1'b0;
		job_desc = cur_desc;
	endtask

	task automatic finish_job;
		while (vertex_index < int'(cur_desc.vertex_count))
			@(negedge clock);
		assert (busy === 1'b0) else
			stop_on_error("busy still high after the last vertex of the job");
		assert (cmd_index == 2 * chunk_total(cur_desc)) else
			stop_on_error($sformatf("ERR read_cmd count got %h expected %h",
				cmd_index, 2 * chunk_total(cur_desc)));
		assert (pend_due.size() == 0) else
			stop_on_error("read commands were left without a data line");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin : main
		start        = 1'b0;
		job_desc     = '0;
		cur_desc     = '0;
		cmd_index    = 0;
		vertex_index = 0;
		rstn         = 1'b0;
		repeat (16) @(posedge clock);
		#1;
		rstn = 1'b1;

		// idle after reset, pops on an empty queue
		consume_en = 1'b1;
		repeat (20) begin
			@(negedge clock);
			check_idle_outputs();
		end

		// short last chunk of 4
		start_job(100, 64'h0000_0001_2000_0000, 64'h0000_0003_4000_0100);
		finish_job();

		start_job(32, 64'h0000_0000_8000_1000, 64'h0000_0000_9000_2000);
		finish_job();
		start_job(1, 64'h0000_0002_0000_0040, 64'h0000_0002_0001_0080);
		finish_job();

		// back-pressure, consumer stalled
		consume_en = 1'b0;
		start_job(200, 64'h0000_0010_0000_0000, 64'h0000_0020_0000_0000);
		while (cmd_index < 4)
			@(negedge clock);
		repeat (hold_window) @(negedge clock);
		assert (cmd_index == 4) else
			stop_on_error($sformatf("ERR read_cmd count got %h expected %h", cmd_index, 4));
		assert (read_request === 1'b0) else
			stop_on_error($sformatf("ERR read_request got %h expected 0", read_request));
		assert (busy === 1'b1) else
			stop_on_error($sformatf("ERR busy got %h expected 1", busy));
		consume_en = 1'b1;
		finish_job();

		// stray start, then ids restart
		start_job(70, 64'h0000_0004_0000_0200, 64'h0000_0005_0000_0300);
		repeat (2) @(negedge clock);
		send_stray_start();
		finish_job();
		start_job(45, 64'h0000_0006_1234_0000, 64'h0000_0007_5678_0000);
		finish_job();

		consume_en = 1'b0;
		repeat (10) @(negedge clock);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- tb.f
design/vertex_pkg.sv
design/sync_fifo.sv
design/vertex_read_sequencer.sv
design/vertex_line_unpacker.sv
design/vertex_job_control.sv
sim/tb_vertex_job_control.sv
